/* verilog/memPkg.sv */
package memPkg;

    // processor side address and word widths
    localparam int AddrWidth = 32;
    localparam int WordWidth = 32;

    // the RAM moves one byte per cycle
    localparam int ByteWidth = 8;

    // access length field, holds 1, 2 or 4
    localparam int LenWidth = 3;

    // RAM size in bytes, only the low address bits reach the array
    localparam int RamDepth = 4096;
    localparam int RamAddrWidth = $clog2(RamDepth);

    // instruction fetch always moves a whole word
    localparam logic [LenWidth-1:0] InstLen = 3'd4;

    // bytes per word, for slicing and assembly
    localparam int WordBytes = WordWidth / ByteWidth;

endpackage

/* verilog/ctrlPkg.sv */
package ctrlPkg;

    // kind of transfer held by the controller
    typedef enum logic [1:0] {
        Idle      = 2'd0,
        ReadInst  = 2'd1,
        ReadData  = 2'd2,
        WriteData = 2'd3
    } xferKind_t;

    // data cache request opcode
    typedef enum logic {
        Load  = 1'b0,
        Store = 1'b1
    } lsOp_t;

endpackage

/* verilog/memCmdIf.sv */
`timescale 1ns/1ps

interface memCmdIf;

    // granted transfer, registered in the arbiter
    logic                           start;
    ctrlPkg::xferKind_t             kind;
    logic [memPkg::AddrWidth-1:0]   addr;
    logic [memPkg::LenWidth-1:0]    len;
    logic [memPkg::WordWidth-1:0]   wdata;

    // result, valid only while done is high
    logic                           done;
    logic [memPkg::WordWidth-1:0]   rdata;

    modport arbiter (
        output start,
        output kind,
        output addr,
        output len,
        output wdata,
        input  done,
        input  rdata
    );

    modport sequencer (
        input  start,
        input  kind,
        input  addr,
        input  len,
        input  wdata,
        output done,
        output rdata
    );

endinterface

/* verilog/memBusIf.sv */
`timescale 1ns/1ps

interface memBusIf;

    logic                           write;
    logic [memPkg::AddrWidth-1:0]   addr;
    logic [memPkg::ByteWidth-1:0]   wdata;
    // registered read data, one cycle behind addr
    logic [memPkg::ByteWidth-1:0]   rdata;

    modport ctrl (
        output write,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram (
        input  write,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* verilog/byteRam.sv */
`timescale 1ns/1ps

module byteRam (
    input  logic clk,
    memBusIf.ram bus
);

    logic [memPkg::ByteWidth-1:0]    mem [memPkg::RamDepth];
    logic [memPkg::RamAddrWidth-1:0] idx;

    // upper address bits are ignored
    assign idx = bus.addr[memPkg::RamAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (bus.write) begin
            mem[idx] <= bus.wdata;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        bus.rdata <= mem[idx];
    end

endmodule

/* verilog/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_rdy,
    input  logic                           i_ioBufferFull,

    input  logic                           i_infEn,
    input  logic [memPkg::AddrWidth-1:0]   i_infAddr,
    output logic                           o_infDone,
    output logic [memPkg::WordWidth-1:0]   o_infInst,

    input  logic                           i_dcEn,
    input  ctrlPkg::lsOp_t                 i_dcLs,
    input  logic [memPkg::LenWidth-1:0]    i_dcLen,
    input  logic [memPkg::AddrWidth-1:0]   i_dcAddr,
    input  logic [memPkg::WordWidth-1:0]   i_dcData,
    output logic                           o_dcDone,
    output logic [memPkg::WordWidth-1:0]   o_dcData,

    memCmdIf.arbiter                       cmd
);

    logic stall;
    ctrlPkg::xferKind_t owner;

    assign stall = !i_rdy || i_ioBufferFull;
    assign cmd.kind = owner;

    // data cache wins, fetch only when the cache is quiet
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ctrlPkg::Idle;
            cmd.start <= 1'b0;
        end else if (!stall) begin
            cmd.start <= 1'b0;
            if (owner == ctrlPkg::Idle) begin
                if (i_dcEn) begin
                    owner <= (i_dcLs == ctrlPkg::Store) ? ctrlPkg::WriteData : ctrlPkg::ReadData;
                    cmd.start <= 1'b1;
                end else if (i_infEn) begin
                    owner <= ctrlPkg::ReadInst;
                    cmd.start <= 1'b1;
                end
            end else if (cmd.done) begin
                owner <= ctrlPkg::Idle;
            end
        end
    end

    // command fields, held until the next grant
    always_ff @(posedge clk) begin
        if (!stall && owner == ctrlPkg::Idle) begin
            if (i_dcEn) begin
                cmd.addr <= i_dcAddr;
                cmd.len <= i_dcLen;
                cmd.wdata <= i_dcData;
            end else if (i_infEn) begin
                cmd.addr <= i_infAddr;
                cmd.len <= memPkg::InstLen;
            end
        end
    end

    // result goes back to the owner only
    assign o_infDone = (owner == ctrlPkg::ReadInst) && cmd.done;
    assign o_infInst = o_infDone ? cmd.rdata : '0;
    assign o_dcDone = ((owner == ctrlPkg::ReadData) || (owner == ctrlPkg::WriteData)) && cmd.done;
    assign o_dcData = ((owner == ctrlPkg::ReadData) && cmd.done) ? cmd.rdata : '0;

endmodule

/* verilog/memSequencer.sv */
`timescale 1ns/1ps

module memSequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_rdy,
    input  logic       i_ioBufferFull,
    memCmdIf.sequencer cmd,
    memBusIf.ctrl      bus
);

    logic                           stall;
    logic                           active;
    logic [memPkg::LenWidth-1:0]    step;
    logic [memPkg::LenWidth-1:0]    byteIdx;
    logic [memPkg::WordWidth-1:0]   asmWord;
    logic                           isRead;
    logic                           lastStep;

    assign stall = !i_rdy || i_ioBufferFull;

    assign isRead = (cmd.kind == ctrlPkg::ReadInst) || (cmd.kind == ctrlPkg::ReadData);

    // a read ends one step after its last address, the byte is still in flight
    assign lastStep = isRead ? (step == cmd.len) : (step == cmd.len - 1'b1);

    // while stalled keep presenting the previous byte address so the
    // registered RAM output still holds the byte expected at this step
    assign byteIdx = stall ? step - 1'b1 : step;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            step <= '0;
        end else if (!stall) begin
            if (cmd.start) begin
                active <= 1'b1;
                step <= '0;
            end else if (active) begin
                if (lastStep) begin
                    active <= 1'b0;
                    step <= '0;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // little endian assembly, byte k lands one step after it was addressed
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (cmd.start) begin
                asmWord <= '0;
            end else if (active && isRead && step != '0 && !lastStep) begin
                asmWord[memPkg::ByteWidth*(step-1'b1) +: memPkg::ByteWidth] <= bus.rdata;
            end
        end
    end

    assign bus.addr = cmd.addr + memPkg::AddrWidth'(byteIdx);
    assign bus.wdata = memPkg::ByteWidth'(cmd.wdata >> (memPkg::ByteWidth * step));
    assign bus.write = active && !isRead && !stall;

    assign cmd.done = active && !stall && lastStep;

    // arriving byte goes on top, upper bytes stay zero from the clear at start
    assign cmd.rdata = asmWord
        | (memPkg::WordWidth'(bus.rdata) << (memPkg::ByteWidth * (cmd.len - 1'b1)));

endmodule

/* verilog/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_rdy,
    input  logic                           i_ioBufferFull,

    input  logic                           i_infEn,
    input  logic [memPkg::AddrWidth-1:0]   i_infAddr,
    output logic                           o_infDone,
    output logic [memPkg::WordWidth-1:0]   o_infInst,

    input  logic                           i_dcEn,
    input  ctrlPkg::lsOp_t                 i_dcLs,
    input  logic [memPkg::LenWidth-1:0]    i_dcLen,
    input  logic [memPkg::AddrWidth-1:0]   i_dcAddr,
    input  logic [memPkg::WordWidth-1:0]   i_dcData,
    output logic                           o_dcDone,
    output logic [memPkg::WordWidth-1:0]   o_dcData
);

    memCmdIf cmdIf ();
    memBusIf busIf ();

    memArbiter memArbiter_i (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_infEn        (i_infEn),
        .i_infAddr      (i_infAddr),
        .o_infDone      (o_infDone),
        .o_infInst      (o_infInst),
        .i_dcEn         (i_dcEn),
        .i_dcLs         (i_dcLs),
        .i_dcLen        (i_dcLen),
        .i_dcAddr       (i_dcAddr),
        .i_dcData       (i_dcData),
        .o_dcDone       (o_dcDone),
        .o_dcData       (o_dcData),
        .cmd            (cmdIf.arbiter)
    );

    memSequencer memSequencer_i (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .cmd            (cmdIf.sequencer),
        .bus            (busIf.ctrl)
    );

    byteRam byteRam_i (
        .clk (clk),
        .bus (busIf.ram)
    );

endmodule

/* tests/memSubsystem_assert.sv */
`timescale 1ns/1ps

module memSubsystemAssert (
    input logic clk,
    input logic rst,
    input logic i_infEn,
    input logic i_dcEn,
    input logic i_infDone,
    input logic i_dcDone
);

    // both done outputs are cleared by the reset edge
    doneLowInReset: assert property (@(posedge clk) rst |=> (!i_infDone && !i_dcDone))
        else $error("done high during reset");

    // one transfer at a time
    oneDone: assert property (@(posedge clk) disable iff (rst) !(i_infDone && i_dcDone))
        else $error("fetch and data done high together");

    infDoneNeedsEn: assert property (@(posedge clk) disable iff (rst) i_infDone |-> i_infEn)
        else $error("fetch done without fetch enable");

    dcDoneNeedsEn: assert property (@(posedge clk) disable iff (rst) i_dcDone |-> i_dcEn)
        else $error("data done without data enable");

endmodule

bind memSubsystem memSubsystemAssert memSubsystemAssert_i (
    .clk       (clk),
    .rst       (rst),
    .i_infEn   (i_infEn),
    .i_dcEn    (i_dcEn),
    .i_infDone (o_infDone),
    .i_dcDone  (o_dcDone)
);

/* tests/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb;

    localparam int ClkPeriod = 4;
    localparam int ResetCycles = 3;
    localparam int DoneTimeout = 40;
    localparam int NumPairs = 8;
    localparam int StallCycles = 3;
    // pairs in the first test plus the fixed transfers of the others
    localparam int NumTransfers = 2 * NumPairs + 28;
    localparam int WorstCycles = 5 + StallCycles + 4;
    localparam int WatchdogMargin = 4;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           i_rdy;
    logic                           i_ioBufferFull;
    logic                           i_infEn;
    logic [memPkg::AddrWidth-1:0]   i_infAddr;
    logic                           o_infDone;
    logic [memPkg::WordWidth-1:0]   o_infInst;
    logic                           i_dcEn;
    ctrlPkg::lsOp_t                 i_dcLs;
    logic [memPkg::LenWidth-1:0]    i_dcLen;
    logic [memPkg::AddrWidth-1:0]   i_dcAddr;
    logic [memPkg::WordWidth-1:0]   i_dcData;
    logic                           o_dcDone;
    logic [memPkg::WordWidth-1:0]   o_dcData;

    // reference copy of the RAM, written on every store the testbench issues
    logic [memPkg::ByteWidth-1:0]   refMem [memPkg::RamDepth];
    integer                         seed = 80;
    int                             checks;
    int                             testErrors;
    int                             passCount;
    int                             failCount;

    memSubsystem memSubsystem_i (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_infEn        (i_infEn),
        .i_infAddr      (i_infAddr),
        .o_infDone      (o_infDone),
        .o_infInst      (o_infInst),
        .i_dcEn         (i_dcEn),
        .i_dcLs         (i_dcLs),
        .i_dcLen        (i_dcLen),
        .i_dcAddr       (i_dcAddr),
        .i_dcData       (i_dcData),
        .o_dcDone       (o_dcDone),
        .o_dcData       (o_dcData)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] randAddr();
        return $unsigned($random(seed)) & (memPkg::RamDepth - 1);
    endfunction

    // little endian, bytes above len stay zero
    function automatic logic [31:0] refWord(input logic [31:0] addr, input int len);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[8*k +: 8] = refMem[(addr + k) & (memPkg::RamDepth - 1)];
        end
        return w;
    endfunction

    task automatic refStore(input logic [31:0] addr, input int len, input logic [31:0] wdata);
        for (int k = 0; k < len; k++) begin
            refMem[(addr + k) & (memPkg::RamDepth - 1)] = wdata[8*k +: 8];
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[FAIL] %0d ns %s expected %h got %h", $time, name, expected, actual);
            testErrors++;
        end
    endtask

    // counts falling edges from the edge that drove the request
    task automatic waitDone(input bit dataSide, output int cycles,
                            output logic [31:0] data, output bit otherSeen);
        bit seen;
        seen = 1'b0;
        otherSeen = 1'b0;
        cycles = 0;
        data = '0;
        while (!seen && cycles < DoneTimeout) begin
            @(negedge clk);
            cycles++;
            if (dataSide ? o_infDone : o_dcDone) begin
                otherSeen = 1'b1;
            end
            if (dataSide ? o_dcDone : o_infDone) begin
                seen = 1'b1;
                data = dataSide ? o_dcData : o_infInst;
            end
        end
        if (!seen) begin
            $display("%0d ns: the %s port never raised its done pulse", $time,
                     dataSide ? "data cache" : "fetch");
            testErrors++;
        end
    endtask

    task automatic dcTransfer(input ctrlPkg::lsOp_t op, input logic [31:0] addr, input int len,
                              input logic [31:0] wdata, output int lat, output logic [31:0] rdata);
        int cycles;
        bit other;
        @(posedge clk);
        i_dcEn <= 1'b1;
        i_dcLs <= op;
        i_dcLen <= memPkg::LenWidth'(len);
        i_dcAddr <= addr;
        i_dcData <= wdata;
        waitDone(1'b1, cycles, rdata, other);
        lat = cycles - 2;
        @(posedge clk);
        i_dcEn <= 1'b0;
        if (op == ctrlPkg::Store) begin
            refStore(addr, len, wdata);
        end
    endtask

    task automatic fetchTransfer(input logic [31:0] addr, output int lat,
                                 output logic [31:0] inst, output bit dcSeen);
        int cycles;
        @(posedge clk);
        i_infEn <= 1'b1;
        i_infAddr <= addr;
        waitDone(1'b0, cycles, inst, dcSeen);
        lat = cycles - 2;
        @(posedge clk);
        i_infEn <= 1'b0;
    endtask

    // stall starts three edges after the request, at byte step 1, and lasts StallCycles
    task automatic stalledTransfer(input ctrlPkg::lsOp_t op, input logic [31:0] addr,
                                   input logic [31:0] wdata, input bit useRdy,
                                   output int lat, output logic [31:0] rdata);
        int cycles;
        bit other;
        @(posedge clk);
        i_dcEn <= 1'b1;
        i_dcLs <= op;
        i_dcLen <= 3'd4;
        i_dcAddr <= addr;
        i_dcData <= wdata;
        fork
            waitDone(1'b1, cycles, rdata, other);
            begin
                repeat (3) @(posedge clk);
                if (useRdy) begin
                    i_rdy <= 1'b0;
                end else begin
                    i_ioBufferFull <= 1'b1;
                end
                repeat (StallCycles) @(posedge clk);
                i_rdy <= 1'b1;
                i_ioBufferFull <= 1'b0;
            end
        join
        lat = cycles - 2;
        @(posedge clk);
        i_dcEn <= 1'b0;
        if (op == ctrlPkg::Store) begin
            refStore(addr, 4, wdata);
        end
    endtask

    task automatic finishTest(input string name);
        $display("%-10s %0d checks, %0d errors", name, checks, testErrors);
        if (testErrors == 0) begin
            passCount++;
        end else begin
            failCount++;
        end
        checks = 0;
        testErrors = 0;
    endtask

    task automatic testStoreLoad();
        logic [31:0] addr;
        logic [31:0] rdata;
        int len;
        int lat;
        for (int i = 0; i < NumPairs; i++) begin
            len = 1 << ($unsigned($random(seed)) % 3);
            addr = randAddr();
            dcTransfer(ctrlPkg::Store, addr, len, $random(seed), lat, rdata);
            dcTransfer(ctrlPkg::Load, addr, len, '0, lat, rdata);
            checkValue("o_dcData", refWord(addr, len), rdata);
        end
        finishTest("storeLoad");
    endtask

    task automatic testFetch();
        logic [31:0] addr;
        logic [31:0] inst;
        int lat;
        bit dcSeen;
        for (int i = 0; i < 3; i++) begin
            addr = randAddr();
            dcTransfer(ctrlPkg::Store, addr, 4, $random(seed), lat, inst);
            fetchTransfer(addr, lat, inst, dcSeen);
            checkValue("o_infInst", refWord(addr, 4), inst);
            checkValue("o_dcDone", 1'b0, dcSeen);
        end
        finishTest("fetch");
    endtask

    task automatic testLatency();
        logic [31:0] addr;
        logic [31:0] rdata;
        int lat;
        bit dcSeen;
        for (int len = 1; len <= 4; len = len * 2) begin
            addr = randAddr();
            dcTransfer(ctrlPkg::Store, addr, len, $random(seed), lat, rdata);
            checkValue("o_dcDone store latency", len, lat);
            dcTransfer(ctrlPkg::Load, addr, len, '0, lat, rdata);
            checkValue("o_dcDone load latency", len + 1, lat);
            fetchTransfer(addr, lat, rdata, dcSeen);
            checkValue("o_infDone latency", 5, lat);
        end
        finishTest("latency");
    endtask

    task automatic testPriority();
        logic [31:0] dataAddr;
        logic [31:0] instAddr;
        logic [31:0] dcWord;
        logic [31:0] infWord;
        int n;
        int dcAt;
        int infAt;
        int lat;
        bit dropDc;
        bit dropInf;
        dataAddr = randAddr();
        // far enough apart that the two words never overlap
        instAddr = dataAddr ^ 32'h800;
        dcTransfer(ctrlPkg::Store, dataAddr, 4, $random(seed), lat, dcWord);
        dcTransfer(ctrlPkg::Store, instAddr, 4, $random(seed), lat, dcWord);
        @(posedge clk);
        i_dcEn <= 1'b1;
        i_dcLs <= ctrlPkg::Load;
        i_dcLen <= 3'd4;
        i_dcAddr <= dataAddr;
        i_infEn <= 1'b1;
        i_infAddr <= instAddr;
        n = 0;
        dcAt = 0;
        infAt = 0;
        while ((dcAt == 0 || infAt == 0) && n < 2 * DoneTimeout) begin
            @(negedge clk);
            n++;
            dropDc = o_dcDone;
            dropInf = o_infDone;
            if (o_dcDone && dcAt == 0) begin
                dcAt = n;
                dcWord = o_dcData;
            end
            if (o_infDone && infAt == 0) begin
                infAt = n;
                infWord = o_infInst;
            end
            if (dropDc || dropInf) begin
                @(posedge clk);
                if (dropDc) i_dcEn <= 1'b0;
                if (dropInf) i_infEn <= 1'b0;
            end
        end
        @(posedge clk);
        i_dcEn <= 1'b0;
        i_infEn <= 1'b0;
        checks++;
        assert (dcAt != 0 && infAt > dcAt) else begin
            $display("%0d ns: the data load did not finish before the fetch", $time);
            testErrors++;
        end
        checkValue("o_dcDone cycle", 7, dcAt);
        checkValue("o_dcData", refWord(dataAddr, 4), dcWord);
        checkValue("o_infInst", refWord(instAddr, 4), infWord);
        finishTest("priority");
    endtask

    task automatic testStall();
        logic [31:0] addr;
        logic [31:0] rdata;
        int lat;
        addr = randAddr();
        dcTransfer(ctrlPkg::Store, addr, 4, $random(seed), lat, rdata);
        stalledTransfer(ctrlPkg::Store, addr, $random(seed), 1'b1, lat, rdata);
        checkValue("o_dcDone stalled store latency", 4 + StallCycles, lat);
        dcTransfer(ctrlPkg::Load, addr, 4, '0, lat, rdata);
        checkValue("o_dcData", refWord(addr, 4), rdata);
        stalledTransfer(ctrlPkg::Load, addr, '0, 1'b0, lat, rdata);
        checkValue("o_dcDone stalled load latency", 5 + StallCycles, lat);
        checkValue("o_dcData", refWord(addr, 4), rdata);
        finishTest("stall");
    endtask

    task automatic testNarrow();
        logic [31:0] addr;
        logic [31:0] rdata;
        int lat;
        addr = randAddr() & ~32'h3;
        dcTransfer(ctrlPkg::Store, addr, 4, $random(seed), lat, rdata);
        dcTransfer(ctrlPkg::Store, addr + 1, 1, $random(seed), lat, rdata);
        dcTransfer(ctrlPkg::Load, addr, 4, '0, lat, rdata);
        checkValue("o_dcData", refWord(addr, 4), rdata);
        dcTransfer(ctrlPkg::Store, addr + 2, 2, $random(seed), lat, rdata);
        dcTransfer(ctrlPkg::Load, addr, 4, '0, lat, rdata);
        checkValue("o_dcData", refWord(addr, 4), rdata);
        finishTest("narrow");
    endtask

    initial begin
        #(ClkPeriod * (ResetCycles + NumTransfers * WorstCycles * WatchdogMargin));
        $display("watchdog expired before all transfers finished");
        $display("test failed");
        $finish;
    end

    initial begin
        rst <= 1'b1;
        i_rdy <= 1'b1;
        i_ioBufferFull <= 1'b0;
        i_infEn <= 1'b0;
        i_infAddr <= '0;
        i_dcEn <= 1'b0;
        i_dcLs <= ctrlPkg::Load;
        i_dcLen <= '0;
        i_dcAddr <= '0;
        i_dcData <= '0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        testStoreLoad();
        testFetch();
        testLatency();
        testPriority();
        testStall();
        testNarrow();
        $display("tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/memPkg.sv
verilog/ctrlPkg.sv
verilog/memCmdIf.sv
verilog/memBusIf.sv
verilog/byteRam.sv
verilog/memArbiter.sv
verilog/memSequencer.sv
verilog/memSubsystem.sv
tests/memSubsystem_assert.sv
tests/memSubsystemTb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - verilog/memPkg.sv
      - verilog/ctrlPkg.sv
      - verilog/memCmdIf.sv
      - verilog/memBusIf.sv
      - verilog/byteRam.sv
      - verilog/memArbiter.sv
      - verilog/memSequencer.sv
      - verilog/memSubsystem.sv
  - target: test
    files:
      - tests/memSubsystem_assert.sv
      - tests/memSubsystemTb.sv
